//--- hdl/mcu_settings.svh
`ifndef MCU_SETTINGS_SVH
`define MCU_SETTINGS_SVH

// Widths shared by the memory control unit

// BRAM address width, also the width of a run length
`define MCU_ADDR_W 10

// Word width of the data and grid RAMs and their streams
`define MCU_DATA_W 16

// Word width of the scale RAM and its stream
`define MCU_SCLE_W 16

// A zero length is rejected by the sequencer
// RAM reads take one cycle from en to rddata
// Stream words leave in address order
// No sideband fields travel with a beat

`endif

//--- hdl/mcu_pkg.sv
package mcu_pkg;

  // Global run sequencer
  typedef enum logic [2:0] {
    SEQ_IDLE  = 3'd0,
    SEQ_CHECK = 3'd1,
    SEQ_RUN   = 3'd2,
    SEQ_DONE  = 3'd3,
    SEQ_ERROR = 3'd4
  } seq_state_t;

  // Per-channel BRAM reader
  // DRAIN waits for the buffered words after the final read
  typedef enum logic [1:0] {
    RDR_IDLE  = 2'd0,
    RDR_READ  = 2'd1,
    RDR_DRAIN = 2'd2
  } rdr_state_t;

endpackage

//--- hdl/run_ctrl_if.sv
`timescale 1ns/1ps
`include "mcu_settings.svh"

// Control link between the run logic and one read engine
interface run_ctrl_if;

  // Launch pulse from the sequencer
  logic                   go;
  // Captured run length from the config block
  logic [`MCU_ADDR_W-1:0] length;
  // Pulse when the last beat of the channel is taken
  logic                   done;
  // Reader idle with a zero length
  logic                   len_error;

  modport cfg (
    output length
  );

  modport seq (
    output go,
    input  done,
    input  len_error
  );

  modport rdr (
    input  go,
    input  length,
    output done,
    output len_error
  );

endinterface

//--- hdl/run_config.sv
`timescale 1ns/1ps
`include "mcu_settings.svh"

// Run length registers, loaded once per accepted start
module run_config (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   load,
  input  logic [`MCU_ADDR_W-1:0] data_size,
  input  logic [`MCU_ADDR_W-1:0] grid_size,
  input  logic [`MCU_ADDR_W-1:0] scle_size,
  run_ctrl_if.cfg                data_cfg,
  run_ctrl_if.cfg                grid_cfg,
  run_ctrl_if.cfg                scle_cfg
);

  logic [`MCU_ADDR_W-1:0] data_len_q;
  logic [`MCU_ADDR_W-1:0] grid_len_q;
  logic [`MCU_ADDR_W-1:0] scle_len_q;

  // Held until the next accepted start
  always_ff @(posedge clk) begin
    if (rst) begin
      data_len_q <= '0;
      grid_len_q <= '0;
      scle_len_q <= '0;
    end else if (load) begin
      data_len_q <= data_size;
      grid_len_q <= grid_size;
      scle_len_q <= scle_size;
    end
  end

  // Lengths seen by the readers
  always_comb begin
    data_cfg.length = data_len_q;
    grid_cfg.length = grid_len_q;
    scle_cfg.length = scle_len_q;
  end

endmodule

//--- hdl/op_sequencer.sv
`timescale 1ns/1ps

// Global run FSM
// Checks the lengths, launches all readers together and
// collects their completions
module op_sequencer (
  input  logic    clk,
  input  logic    rst,
  input  logic    operation_start,
  output logic    load,
  run_ctrl_if.seq data_seq,
  run_ctrl_if.seq grid_seq,
  run_ctrl_if.seq scle_seq,
  output logic    operation_in_progress,
  output logic    operation_complete,
  output logic    operation_error
);

  import mcu_pkg::*;

  seq_state_t state;
  seq_state_t state_next;

  // Sticky completion flags, bit 0 data, bit 1 grid, bit 2 scale
  logic [2:0] done_q;
  logic [2:0] done_in;
  logic       any_len_error;
  logic       launch;

  assign done_in = {scle_seq.done, grid_seq.done, data_seq.done};

  assign any_len_error = data_seq.len_error | grid_seq.len_error | scle_seq.len_error;

  // Start is only taken while idle
  assign load = (state == SEQ_IDLE) && operation_start;

  // Lengths were loaded on the previous edge and are checked here
  assign launch = (state == SEQ_CHECK) && !any_len_error;

  assign data_seq.go = launch;
  assign grid_seq.go = launch;
  assign scle_seq.go = launch;

  always_comb begin
    state_next = state;
    case (state)
      SEQ_IDLE: begin
        if (operation_start) begin
          state_next = SEQ_CHECK;
        end
      end
      SEQ_CHECK: begin
        if (any_len_error) begin
          state_next = SEQ_ERROR;
        end else begin
          state_next = SEQ_RUN;
        end
      end
      SEQ_RUN: begin
        if (&done_q) begin
          state_next = SEQ_DONE;
        end
      end
      SEQ_DONE: begin
        state_next = SEQ_IDLE;
      end
      SEQ_ERROR: begin
        state_next = SEQ_IDLE;
      end
      default: begin
        state_next = SEQ_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state  <= SEQ_IDLE;
      done_q <= '0;
    end else begin
      state <= state_next;
      if (launch) begin
        done_q <= '0;
      end else if (state == SEQ_RUN) begin
        done_q <= done_q | done_in;
      end
    end
  end

  // Status decoded from the registered state
  assign operation_in_progress = (state == SEQ_CHECK) || (state == SEQ_RUN);
  assign operation_complete    = (state == SEQ_DONE);
  assign operation_error       = (state == SEQ_ERROR);

endmodule

//--- hdl/bram_stream_reader.sv
`timescale 1ns/1ps
`include "mcu_settings.svh"

// Walks one BRAM from address zero and streams the words out
// A two-entry buffer absorbs the read latency under back-pressure
module bram_stream_reader #(
  parameter int WORD_W = `MCU_DATA_W
) (
  input  logic                   clk,
  input  logic                   rst,
  run_ctrl_if.rdr                ctrl,
  output logic                   bram_en,
  output logic [`MCU_ADDR_W-1:0] bram_addr,
  input  logic [WORD_W-1:0]      bram_rddata,
  output logic [WORD_W-1:0]      tdata,
  output logic                   tvalid,
  input  logic                   tready,
  output logic                   tlast
);

  import mcu_pkg::*;

  rdr_state_t state;

  logic [`MCU_ADDR_W-1:0] addr_q;
  logic [`MCU_ADDR_W-1:0] last_addr;
  logic                   final_rd;

  // Read issued last cycle, word is on bram_rddata now
  logic rd_pending;
  logic rd_pending_last;

  // Output buffer
  logic [WORD_W-1:0] buf_data [2];
  logic              buf_last [2];
  logic              wr_ptr;
  logic              rd_ptr;
  logic [1:0]        count;

  logic [2:0] occupancy;
  logic       pop;
  logic       has_room;

  assign last_addr = ctrl.length - 1'b1;
  assign final_rd  = (addr_q == last_addr);

  assign pop = tvalid && tready;

  // Stored words plus the one in flight, a pop frees a slot this cycle
  assign occupancy = {1'b0, count} + {2'b00, rd_pending};
  assign has_room  = (occupancy < 3'd2) || pop;

  assign bram_en   = (state == RDR_READ) && has_room;
  assign bram_addr = addr_q;

  always_ff @(posedge clk) begin
    if (rst) begin
      state      <= RDR_IDLE;
      addr_q     <= '0;
      rd_pending <= 1'b0;
    end else begin
      rd_pending <= bram_en;
      case (state)
        RDR_IDLE: begin
          if (ctrl.go) begin
            addr_q <= '0;
            state  <= RDR_READ;
          end
        end
        RDR_READ: begin
          if (bram_en) begin
            addr_q <= addr_q + 1'b1;
            if (final_rd) begin
              state <= RDR_DRAIN;
            end
          end
        end
        RDR_DRAIN: begin
          if (ctrl.done) begin
            state <= RDR_IDLE;
          end
        end
        default: begin
          state <= RDR_IDLE;
        end
      endcase
    end
  end

  // Tag follows the read through the RAM latency
  always_ff @(posedge clk) begin
    if (bram_en) begin
      rd_pending_last <= final_rd;
    end
  end

  always_ff @(posedge clk) begin
    if (rd_pending) begin
      buf_data[wr_ptr] <= bram_rddata;
      buf_last[wr_ptr] <= rd_pending_last;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr <= 1'b0;
      rd_ptr <= 1'b0;
      count  <= '0;
    end else begin
      if (rd_pending) begin
        wr_ptr <= ~wr_ptr;
      end
      if (pop) begin
        rd_ptr <= ~rd_ptr;
      end
      count <= count + {1'b0, rd_pending} - {1'b0, pop};
    end
  end

  // Head entry stays put until it is taken
  assign tvalid = (count != 2'd0);
  assign tdata  = buf_data[rd_ptr];
  assign tlast  = tvalid && buf_last[rd_ptr];

  assign ctrl.done      = (state == RDR_DRAIN) && pop && tlast;
  assign ctrl.len_error = (state == RDR_IDLE) && (ctrl.length == '0);

endmodule

//--- hdl/mcu_top.sv
`timescale 1ns/1ps
`include "mcu_settings.svh"

// Memory-to-stream control unit
module mcu_top (
  input  logic                   clk,
  input  logic                   rst,

  // Run control
  input  logic                   operation_start,
  input  logic [`MCU_ADDR_W-1:0] data_size,
  input  logic [`MCU_ADDR_W-1:0] grid_size,
  input  logic [`MCU_ADDR_W-1:0] scle_size,

  // Data RAM
  output logic                   data_bram_en,
  output logic [`MCU_ADDR_W-1:0] data_bram_addr,
  input  logic [`MCU_DATA_W-1:0] data_bram_rddata,

  // Grid RAM
  output logic                   grid_bram_en,
  output logic [`MCU_ADDR_W-1:0] grid_bram_addr,
  input  logic [`MCU_DATA_W-1:0] grid_bram_rddata,

  // Scale RAM
  output logic                   scle_bram_en,
  output logic [`MCU_ADDR_W-1:0] scle_bram_addr,
  input  logic [`MCU_SCLE_W-1:0] scle_bram_rddata,

  // Output streams
  output logic [`MCU_DATA_W-1:0] m_axis_data_tdata,
  output logic                   m_axis_data_tvalid,
  input  logic                   m_axis_data_tready,
  output logic                   m_axis_data_tlast,

  output logic [`MCU_DATA_W-1:0] m_axis_grid_tdata,
  output logic                   m_axis_grid_tvalid,
  input  logic                   m_axis_grid_tready,
  output logic                   m_axis_grid_tlast,

  output logic [`MCU_SCLE_W-1:0] m_axis_scle_tdata,
  output logic                   m_axis_scle_tvalid,
  input  logic                   m_axis_scle_tready,
  output logic                   m_axis_scle_tlast,

  // Status
  output logic                   operation_in_progress,
  output logic                   operation_complete,
  output logic                   operation_error
);

  logic load;

  run_ctrl_if data_ctrl ();
  run_ctrl_if grid_ctrl ();
  run_ctrl_if scle_ctrl ();

  run_config u_cfg (
    .clk      (clk),
    .rst      (rst),
    .load     (load),
    .data_size(data_size),
    .grid_size(grid_size),
    .scle_size(scle_size),
    .data_cfg (data_ctrl),
    .grid_cfg (grid_ctrl),
    .scle_cfg (scle_ctrl)
  );

  op_sequencer u_seq (
    .clk                  (clk),
    .rst                  (rst),
    .operation_start      (operation_start),
    .load                 (load),
    .data_seq             (data_ctrl),
    .grid_seq             (grid_ctrl),
    .scle_seq             (scle_ctrl),
    .operation_in_progress(operation_in_progress),
    .operation_complete   (operation_complete),
    .operation_error      (operation_error)
  );

  bram_stream_reader #(.WORD_W(`MCU_DATA_W)) u_data_rdr (
    .clk        (clk),
    .rst        (rst),
    .ctrl       (data_ctrl),
    .bram_en    (data_bram_en),
    .bram_addr  (data_bram_addr),
    .bram_rddata(data_bram_rddata),
    .tdata      (m_axis_data_tdata),
    .tvalid     (m_axis_data_tvalid),
    .tready     (m_axis_data_tready),
    .tlast      (m_axis_data_tlast)
  );

  bram_stream_reader #(.WORD_W(`MCU_DATA_W)) u_grid_rdr (
    .clk        (clk),
    .rst        (rst),
    .ctrl       (grid_ctrl),
    .bram_en    (grid_bram_en),
    .bram_addr  (grid_bram_addr),
    .bram_rddata(grid_bram_rddata),
    .tdata      (m_axis_grid_tdata),
    .tvalid     (m_axis_grid_tvalid),
    .tready     (m_axis_grid_tready),
    .tlast      (m_axis_grid_tlast)
  );

  // Scale table has its own word width
  bram_stream_reader #(.WORD_W(`MCU_SCLE_W)) u_scle_rdr (
    .clk        (clk),
    .rst        (rst),
    .ctrl       (scle_ctrl),
    .bram_en    (scle_bram_en),
    .bram_addr  (scle_bram_addr),
    .bram_rddata(scle_bram_rddata),
    .tdata      (m_axis_scle_tdata),
    .tvalid     (m_axis_scle_tvalid),
    .tready     (m_axis_scle_tready),
    .tlast      (m_axis_scle_tlast)
  );

endmodule

//--- verif/bram_model.sv
`timescale 1ns/1ps
`include "mcu_settings.svh"

// Read-only RAM with one cycle from en to rddata
// FILL_KIND 0 is data, 1 is grid and 2 is scale
module bram_model #(
  parameter int WORD_W    = `MCU_DATA_W,
  parameter int FILL_KIND = 0
) (
  input  logic                   clk,
  input  logic                   en,
  input  logic [`MCU_ADDR_W-1:0] addr,
  output logic [WORD_W-1:0]      rddata
);

  function automatic logic [WORD_W-1:0] fill_word(input logic [`MCU_ADDR_W-1:0] a);
    logic [WORD_W-1:0] w;
    w = WORD_W'(a);
    case (FILL_KIND)
      0:       fill_word = w * WORD_W'(3) + WORD_W'(1);
      1:       fill_word = w ^ WORD_W'(16'h5a5a);
      default: fill_word = w + WORD_W'(16'h8000);
    endcase
  endfunction

  always @(posedge clk) begin
    if (en) begin
      rddata <= fill_word(addr);
    end
  end

endmodule

//--- verif/mcu_tb.sv
`timescale 1ns/1ps
`include "mcu_settings.svh"

module mcu_tb;

  localparam int NUM_TESTS  = 6;
  localparam int STRAY_TEST = 5;
  // Data, grid and scale lengths per test
  localparam int TEST_LEN [NUM_TESTS][3] = '{'{5, 8, 3}, '{1, 4, 2}, '{17, 9, 23},
                                            '{6, 0, 4}, '{2, 7, 5}, '{12, 6, 9}};
  // Tests that randomise ready
  localparam bit TEST_RAND [NUM_TESTS] = '{0, 0, 1, 0, 1, 0};

  logic                        clk;
  logic                        rst;
  logic                        operation_start;
  logic [2:0][`MCU_ADDR_W-1:0] size;
  logic                        operation_in_progress;
  logic                        operation_complete;
  logic                        operation_error;
  // Channel 0 is data, 1 is grid and 2 is scale
  logic [2:0]                  bram_en;
  logic [2:0][`MCU_ADDR_W-1:0] bram_addr;
  logic [2:0][`MCU_DATA_W-1:0] bram_rddata;
  logic [2:0][`MCU_DATA_W-1:0] s_data;
  logic [2:0]                  s_valid;
  logic [2:0]                  s_last;
  logic [2:0]                  s_ready = 3'b111;

  int    seed = 32'h720599ef;
  bit    rand_ready = 1'b0;
  bit    new_run = 1'b0;
  bit    new_err = 1'b0;
  bit    run_open = 1'b0;
  bit    err_open = 1'b0;
  int    start_age = 0;
  int    exp_len [3] = '{0, 0, 0};
  int    beat_cnt [3] = '{0, 0, 0};
  int    cycle_count = 0;
  int    err_count = 0;
  int    tests_failed = 0;
  string test_name [NUM_TESTS] = '{"basic", "length_one", "back_pressure",
                                   "length_error", "after_error", "start_ignored"};

  mcu_top u_dut (
    .clk                  (clk),
    .rst                  (rst),
    .operation_start      (operation_start),
    .data_size            (size[0]),
    .grid_size            (size[1]),
    .scle_size            (size[2]),
    .data_bram_en         (bram_en[0]),
    .data_bram_addr       (bram_addr[0]),
    .data_bram_rddata     (bram_rddata[0]),
    .grid_bram_en         (bram_en[1]),
    .grid_bram_addr       (bram_addr[1]),
    .grid_bram_rddata     (bram_rddata[1]),
    .scle_bram_en         (bram_en[2]),
    .scle_bram_addr       (bram_addr[2]),
    .scle_bram_rddata     (bram_rddata[2]),
    .m_axis_data_tdata    (s_data[0]),
    .m_axis_data_tvalid   (s_valid[0]),
    .m_axis_data_tready   (s_ready[0]),
    .m_axis_data_tlast    (s_last[0]),
    .m_axis_grid_tdata    (s_data[1]),
    .m_axis_grid_tvalid   (s_valid[1]),
    .m_axis_grid_tready   (s_ready[1]),
    .m_axis_grid_tlast    (s_last[1]),
    .m_axis_scle_tdata    (s_data[2]),
    .m_axis_scle_tvalid   (s_valid[2]),
    .m_axis_scle_tready   (s_ready[2]),
    .m_axis_scle_tlast    (s_last[2]),
    .operation_in_progress(operation_in_progress),
    .operation_complete   (operation_complete),
    .operation_error      (operation_error)
  );

  for (genvar c = 0; c < 3; c++) begin : g_ram
    bram_model #(.WORD_W(c == 2 ? `MCU_SCLE_W : `MCU_DATA_W), .FILL_KIND(c)) u_ram (
      .clk   (clk),
      .en    (bram_en[c]),
      .addr  (bram_addr[c]),
      .rddata(bram_rddata[c])
    );
  end

  // Reference contents of each RAM
  function automatic logic [15:0] expected_word(input int chan, input int idx);
    logic [15:0] a;
    a = 16'(idx);
    case (chan)
      0:       expected_word = a * 16'd3 + 16'd1;
      1:       expected_word = a ^ 16'h5a5a;
      default: expected_word = a + 16'h8000;
    endcase
  endfunction

  // Twice the sum of longest length plus 20 over all tests
  function automatic int cycle_budget();
    int total;
    int longest;
    total = 0;
    for (int t = 0; t < NUM_TESTS; t++) begin
      longest = 0;
      for (int c = 0; c < 3; c++) begin
        longest = (TEST_LEN[t][c] > longest) ? TEST_LEN[t][c] : longest;
      end
      total += 2 * (longest + 20);
    end
    return total;
  endfunction

  task automatic flag_error(input string msg);
    $display("** Error at %0t ns: %s", $time, msg);
    err_count++;
  endtask

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  always @(negedge clk) begin
    s_ready <= rand_ready ? 3'($random(seed)) : 3'b111;
  end

  // Beat index per channel and open-run flags
  always @(posedge clk) begin
    for (int c = 0; c < 3; c++) begin
      if (new_run) begin
        beat_cnt[c] <= 0;
      end else if (s_valid[c] && s_ready[c]) begin
        beat_cnt[c] <= beat_cnt[c] + 1;
      end
    end
    run_open    <= new_run || (run_open && !operation_complete);
    err_open    <= new_err || (err_open && !operation_error);
    start_age   <= new_run ? 0 : start_age + 1;
    cycle_count <= cycle_count + 1;
    if (cycle_count >= cycle_budget()) begin
      $display("Timeout: the tests did not finish within %0d cycles", cycle_budget());
      $display("Testbench failed");
      $finish;
    end
  end

  for (genvar c = 0; c < 3; c++) begin : g_chk
    assert property (@(posedge clk) disable iff (rst)
        s_valid[c] && s_ready[c] |-> s_data[c] == expected_word(c, beat_cnt[c]) &&
        beat_cnt[c] < exp_len[c] && s_last[c] == (beat_cnt[c] == exp_len[c] - 1))
      else flag_error($sformatf("channel %0d beat %0d has wrong data, last or count",
                                c, beat_cnt[c]));
    // Stalled beat holds still
    assert property (@(posedge clk) disable iff (rst)
        s_valid[c] && !s_ready[c] |=> s_valid[c] && $stable(s_data[c]) && $stable(s_last[c]))
      else flag_error($sformatf("channel %0d beat changed while stalled", c));
    assert property (@(posedge clk) disable iff (rst)
        operation_complete |-> beat_cnt[c] == exp_len[c])
      else flag_error($sformatf("channel %0d gave %0d beats, expected %0d",
                                c, beat_cnt[c], exp_len[c]));
    // Valid rises three cycles after start and only in a good run
    assert property (@(posedge clk) disable iff (rst)
        !run_open || start_age <= 3 |-> s_valid[c] == (run_open && start_age == 3))
      else flag_error($sformatf("channel %0d valid at the wrong time", c));
    // RAM reads only inside a good run
    assert property (@(posedge clk) disable iff (rst)
        !run_open |-> !bram_en[c])
      else flag_error($sformatf("channel %0d RAM read outside a run", c));
  end

  assert property (@(posedge clk) disable iff (rst)
      operation_complete |-> run_open && !operation_in_progress)
    else flag_error("unexpected complete pulse");
  assert property (@(posedge clk) disable iff (rst)
      operation_error |-> err_open)
    else flag_error("unexpected error pulse");
  assert property (@(posedge clk) disable iff (rst)
      run_open && !operation_complete |-> operation_in_progress)
    else flag_error("in progress low during a run");
  assert property (@(posedge clk) disable iff (rst)
      !run_open && !err_open |->
      !operation_in_progress && !operation_complete && !operation_error)
    else flag_error("status output high while idle");

  task automatic run_test(input int idx);
    int errs_before;
    bit bad_len;
    errs_before = err_count;
    bad_len     = (TEST_LEN[idx][0] == 0) || (TEST_LEN[idx][1] == 0) ||
                  (TEST_LEN[idx][2] == 0);
    rand_ready  = TEST_RAND[idx];
    @(negedge clk);
    for (int c = 0; c < 3; c++) begin
      size[c]    = `MCU_ADDR_W'(TEST_LEN[idx][c]);
      exp_len[c] = TEST_LEN[idx][c];
    end
    operation_start = 1'b1;
    new_run         = !bad_len;
    new_err         = bad_len;
    @(negedge clk);
    operation_start = 1'b0;
    new_run         = 1'b0;
    new_err         = 1'b0;
    if (idx == STRAY_TEST) begin
      // Second start with other lengths in the middle of the run
      repeat (4) @(negedge clk);
      size            = {3{`MCU_ADDR_W'(1)}};
      operation_start = 1'b1;
      @(negedge clk);
      operation_start = 1'b0;
    end
    while (!operation_complete && !operation_error) begin
      @(negedge clk);
    end
    repeat (4) @(negedge clk);
    if (err_count != errs_before) begin
      tests_failed++;
    end
    $display("Test %0d %s: %s", idx, test_name[idx],
             (err_count == errs_before) ? "ok" : "FAILED");
  endtask

  initial begin
    rst             = 1'b1;
    operation_start = 1'b0;
    size            = '0;
    repeat (10) @(negedge clk);
    rst = 1'b0;
    repeat (2) @(negedge clk);
    for (int t = 0; t < NUM_TESTS; t++) begin
      run_test(t);
    end
    $display("Tests run %0d, failed %0d, errors %0d", NUM_TESTS, tests_failed, err_count);
    if (err_count == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

//--- list.f
+incdir+hdl
hdl/mcu_pkg.sv
hdl/run_ctrl_if.sv
hdl/run_config.sv
hdl/op_sequencer.sv
hdl/bram_stream_reader.sv
hdl/mcu_top.sv
verif/bram_model.sv
verif/mcu_tb.sv

//--- run.sh
#!/bin/sh
# Compile and run the memory control unit testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
  --top-module mcu_tb -f list.f -o mcu_sim

./obj_dir/mcu_sim > sim.log 2>&1
cat sim.log

if grep -q "Testbench failed" sim.log; then
  echo "Simulation FAILED, see sim.log"
  exit 1
fi
echo "Simulation finished without failures"
